/* crop_key_control.sv */
// Crop offset control from the keyboard strobe channel.
// Cursor keys move the top or left edge, or the bottom or right edge
// while alt is held. Backspace clears all offsets.

`default_nettype none

`include "video_crop_consts.svh"

module crop_key_control
	import video_crop_pkg::*;
(
	input  logic  clk_28,
	input  logic  reset,
	input  key_t  key,
	output crop_t crop
);

	logic adj_stb;
	logic old_stb;
	logic alt;     // either alt key held
	logic act;

	assign adj_stb = key.strobe & (key.ktype == `KEY_TYPE_ADJ);
	assign act     = ~old_stb & adj_stb; // rising edge only

	always_ff @(posedge clk_28) begin
		if (reset) begin
			old_stb <= 1'b0;
			alt     <= 1'b0;
			crop    <= '0;
		end else begin
			old_stb <= adj_stb;
			if (act) begin
				case (key.data)
					`KEY_CLEAR: begin
						crop <= '0;
					end
					`KEY_UP: begin
						if (alt) crop.vbl_b <= crop.vbl_b + `CNT_W'(`V_STEP);
						else     crop.vbl_t <= crop.vbl_t + `CNT_W'(`V_STEP);
					end
					`KEY_DOWN: begin
						if (alt) crop.vbl_b <= crop.vbl_b - `CNT_W'(`V_STEP);
						else     crop.vbl_t <= crop.vbl_t - `CNT_W'(`V_STEP);
					end
					`KEY_LEFT: begin
						if (alt) crop.hbl_r <= crop.hbl_r + `CNT_W'(`H_STEP);
						else     crop.hbl_l <= crop.hbl_l + `CNT_W'(`H_STEP);
					end
					`KEY_RIGHT: begin
						if (alt) crop.hbl_r <= crop.hbl_r - `CNT_W'(`H_STEP);
						else     crop.hbl_l <= crop.hbl_l - `CNT_W'(`H_STEP);
					end
					`KEY_ALT_L_DN, `KEY_ALT_R_DN: begin
						alt <= 1'b1; // press
					end
					`KEY_ALT_L_UP, `KEY_ALT_R_UP: begin
						alt <= 1'b0; // release
					end
					default: ; // other keys ignored
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* h_blank_crop.sv */
// Horizontal side of the crop unit.
// Measures the line from the raw blank and sync edges and produces the
// combined horizontal blank plus a registered horizontal enable.

`default_nettype none

`include "video_crop_consts.svh"

module h_blank_crop
	import video_crop_pkg::*;
(
	input  logic              clk_28,
	input  logic              reset,
	input  raster_t           raster,
	input  crop_t             crop,
	output logic              hbl,
	output logic              hde,
	output logic [`CNT_W-1:0] hsize
);

	logic [`CNT_W-1:0] hcnt; // pixel position from end of hsync
	logic [`CNT_W-1:0] hend; // hblank fall position
	logic [`CNT_W-1:0] hsta; // hblank rise position
	logic [`CNT_W-1:0] hmax; // hsync fall position
	logic              old_hs_n;
	logic              old_hblank;
	logic              shbl; // blank from crop offsets
	logic              fhbl; // forced border blank

	logic [`CNT_W-1:0] shbl_off_at;
	logic [`CNT_W-1:0] shbl_on_at;
	logic [`CNT_W-1:0] fhbl_on_at;
	logic              hblank_fall;
	logic              hblank_rise;
	logic              hs_fall;

	assign hblank_fall = old_hblank & ~raster.hblank;
	assign hblank_rise = ~old_hblank & raster.hblank;
	assign hs_fall     = old_hs_n & ~raster.hs_n;

	assign shbl_off_at = hend + crop.hbl_l - `CNT_W'(`H_EDGE_ADJ);
	assign shbl_on_at  = hsta + crop.hbl_r - `CNT_W'(`H_EDGE_ADJ);
	assign fhbl_on_at  = hmax - `CNT_W'(`H_FORCE_TAIL);

	// sync low always blanks
	assign hbl = fhbl | shbl | ~raster.hs_n;

	//////////////////////////////
	// line measurement
	//////////////////////////////
	always_ff @(posedge clk_28) begin
		if (reset) begin
			hcnt       <= '0;
			hend       <= '0;
			hsta       <= '0;
			hmax       <= '0;
			hsize      <= '0;
			old_hs_n   <= 1'b1;
			old_hblank <= 1'b0;
		end else begin
			old_hs_n   <= raster.hs_n;
			old_hblank <= raster.hblank;

			if (raster.hs_n) hcnt <= hcnt + 1'b1;
			else             hcnt <= '0; // held during sync

			if (hblank_fall) hend <= hcnt;
			if (hblank_rise) begin
				hsta  <= hcnt;
				hsize <= hcnt - hend; // width of the active part
			end
			if (hs_fall) hmax <= hcnt; // line length
		end
	end

	//////////////////////////////
	// blank generation
	//////////////////////////////
	always_ff @(posedge clk_28) begin
		if (reset) begin
			shbl <= 1'b1;
			fhbl <= 1'b1;
			hde  <= 1'b0;
		end else begin
			if (hcnt == shbl_off_at) shbl <= 1'b0;
			if (hcnt == shbl_on_at)  shbl <= 1'b1;

			if (hcnt == `CNT_W'(`H_FORCE_LEAD)) fhbl <= 1'b0;
			if (hcnt == fhbl_on_at)             fhbl <= 1'b1;

			hde <= ~hbl;
		end
	end

endmodule

`default_nettype wire

/* screen_mode_snapshot.sv */
// Per-frame screen snapshot.
// Captures offsets, measured size and resolution at each frame start and
// counts the frames where the mode differs from the previous snapshot.

`default_nettype none

`include "video_crop_consts.svh"

module screen_mode_snapshot
	import video_crop_pkg::*;
(
	input  logic              clk_28,
	input  logic              reset,
	input  logic              frame_start,
	input  crop_t             crop,
	input  logic [`CNT_W-1:0] hsize,
	input  logic [`CNT_W-1:0] vsize,
	input  logic [1:0]        res,
	output screen_info_t      scr
);

	logic mode_changed;

	// compare against what was last captured
	assign mode_changed = (scr.res != res) || (scr.hsize != hsize) || (scr.vsize != vsize);

	always_ff @(posedge clk_28) begin
		if (reset) begin
			scr <= '0;
		end else if (frame_start) begin
			scr.crop  <= crop;
			scr.hsize <= hsize;
			scr.vsize <= vsize;
			scr.res   <= res;
			if (mode_changed) scr.flg <= scr.flg + 1'b1; // wraps at 7 bits
		end
	end

endmodule

`default_nettype wire

/* v_blank_crop.sv */
// Vertical side of the crop unit.
// Counts lines, measures the frame from the composite vertical blank and
// produces the final display enable together with the frame start pulse.
// Vertical blank changes only at the start of a line, on the hbl fall.

`default_nettype none

`include "video_crop_consts.svh"

module v_blank_crop
	import video_crop_pkg::*;
(
	input  logic              clk_28,
	input  logic              reset,
	input  raster_t           raster,
	input  crop_t             crop,
	input  logic              hbl,
	input  logic              hde,
	output logic              de,
	output logic [`CNT_W-1:0] vsize,
	output logic              frame_start
);

	logic [`CNT_W-1:0] vcnt; // line from end of vsync
	logic [`CNT_W-1:0] vend; // composite blank fall line
	logic [`CNT_W-1:0] vsta; // composite blank rise line
	logic [`CNT_W-1:0] vmax; // vsync fall line
	logic              old_vs_n;
	logic              old_hs_n;
	logic              old_vblank;
	logic              old_hbl;
	logic              svbl; // blank from crop offsets
	logic              fvbl; // forced border blank

	logic              vblank_c;
	logic              vde;
	logic [`CNT_W-1:0] svbl_off_at;
	logic [`CNT_W-1:0] svbl_on_at;
	logic [`CNT_W-1:0] fvbl_on_at;

	assign vblank_c = raster.vblank | ~raster.vs_n;

	assign svbl_off_at = vend + crop.vbl_t - `CNT_W'(`V_EDGE_ADJ);
	assign svbl_on_at  = vsta + crop.vbl_b - `CNT_W'(`V_EDGE_ADJ);
	assign fvbl_on_at  = vmax - `CNT_W'(`V_FORCE_TAIL);

	assign frame_start = old_vblank & ~vblank_c;
	assign vde         = ~(fvbl | svbl);
	assign de          = hde & vde;

	//////////////////////////////
	// frame measurement
	//////////////////////////////
	always_ff @(posedge clk_28) begin
		if (reset) begin
			vcnt       <= '0;
			vend       <= '0;
			vsta       <= '0;
			vmax       <= '0;
			vsize      <= '0;
			old_vs_n   <= 1'b1;
			old_hs_n   <= 1'b1;
			old_vblank <= 1'b0; // keeps frame_start low
		end else begin
			old_vs_n   <= raster.vs_n;
			old_hs_n   <= raster.hs_n;
			old_vblank <= vblank_c;

			if (old_hs_n & ~raster.hs_n) vcnt <= vcnt + 1'b1;
			if (~raster.vs_n)            vcnt <= '0;

			if (frame_start) vend <= vcnt;
			if (~old_vblank & vblank_c) begin
				vsta  <= vcnt;
				vsize <= vcnt - vend; // active lines
			end
			if (old_vs_n & ~raster.vs_n) vmax <= vcnt;
		end
	end

	//////////////////////////////
	// vertical blank
	//////////////////////////////
	always_ff @(posedge clk_28) begin
		if (reset) begin
			old_hbl <= 1'b1;
			svbl    <= 1'b1;
			fvbl    <= 1'b1;
		end else begin
			old_hbl <= hbl;
			if (old_hbl & ~hbl) begin
				if (vcnt == svbl_off_at) svbl <= 1'b0;
				if (vcnt == svbl_on_at)  svbl <= 1'b1;

				if (vcnt == `CNT_W'(`V_FORCE_LEAD)) fvbl <= 1'b0;
				if (vcnt == fvbl_on_at)             fvbl <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* video_crop.f */
+incdir+.
video_crop_pkg.sv
h_blank_crop.sv
v_blank_crop.sv
crop_key_control.sv
screen_mode_snapshot.sv
video_crop.sv
video_crop_tb.sv

/* video_crop.sv */
// Top level of the video border-crop unit.
// Takes raw timing, resolution and key strobes on the 28 MHz pixel clock,
// returns the cropped display enable and the per-frame screen snapshot.

`default_nettype none

`include "video_crop_consts.svh"

module video_crop
	import video_crop_pkg::*;
(
	input  logic         clk_28,
	input  logic         reset,
	input  raster_t      raster,
	input  logic [1:0]   res,
	input  key_t         key,
	output logic         de,
	output screen_info_t scr
);

	crop_t             crop;
	logic              hbl;
	logic              hde;
	logic [`CNT_W-1:0] hsize;
	logic [`CNT_W-1:0] vsize;
	logic              frame_start;

	crop_key_control u_keys (
		.clk_28 (clk_28),
		.reset  (reset),
		.key    (key),
		.crop   (crop)
	);

	h_blank_crop u_hcrop (
		.clk_28 (clk_28),
		.reset  (reset),
		.raster (raster),
		.crop   (crop),
		.hbl    (hbl),
		.hde    (hde),
		.hsize  (hsize)
	);

	v_blank_crop u_vcrop (
		.clk_28      (clk_28),
		.reset       (reset),
		.raster      (raster),
		.crop        (crop),
		.hbl         (hbl),
		.hde         (hde),
		.de          (de),
		.vsize       (vsize),
		.frame_start (frame_start)
	);

	screen_mode_snapshot u_snap (
		.clk_28      (clk_28),
		.reset       (reset),
		.frame_start (frame_start),
		.crop        (crop),
		.hsize       (hsize),
		.vsize       (vsize),
		.res         (res),
		.scr         (scr)
	);

endmodule

`default_nettype wire

/* video_crop_consts.svh */
// Constants for the video border-crop unit.
// Include in any file that needs counter widths, key codes or crop margins.
// Numeric margins are plain integers and get cast to the counter width at use.

`ifndef VIDEO_CROP_CONSTS_SVH
`define VIDEO_CROP_CONSTS_SVH

`define CNT_W 12 // pixel and line counters, offsets

// key channel
`define KEY_TYPE_ADJ 2'd3 // adjustment key type
`define KEY_UP       8'h4c
`define KEY_DOWN     8'h4d
`define KEY_LEFT     8'h4f
`define KEY_RIGHT    8'h4e
`define KEY_CLEAR    8'h41 // backspace
`define KEY_ALT_L_DN 8'h64
`define KEY_ALT_R_DN 8'h65
`define KEY_ALT_L_UP 8'he4
`define KEY_ALT_R_UP 8'he5

// offset steps per key press
`define H_STEP 4 // pixels
`define V_STEP 1 // lines

// forced blank margins
`define H_FORCE_LEAD 8
`define H_FORCE_TAIL 8
`define V_FORCE_LEAD 1
`define V_FORCE_TAIL 3

// compare corrections for the crop edges
`define H_EDGE_ADJ 2
`define V_EDGE_ADJ 1

`endif

/* video_crop_pkg.sv */
// Shared types for the video border-crop unit.
// Import with a wildcard in the module header of any block using these bundles.

`default_nettype none

`include "video_crop_consts.svh"

package video_crop_pkg;

	// raw timing from the video core
	typedef struct packed {
		logic hs_n;   // hsync, active low
		logic vs_n;   // vsync, active low
		logic hblank;
		logic vblank;
	} raster_t;

	// crop offsets, all in counter units
	typedef struct packed {
		logic [`CNT_W-1:0] hbl_l; // left edge, pixels
		logic [`CNT_W-1:0] hbl_r; // right edge, pixels
		logic [`CNT_W-1:0] vbl_t; // top edge, lines
		logic [`CNT_W-1:0] vbl_b; // bottom edge, lines
	} crop_t;

	// keyboard strobe channel
	typedef struct packed {
		logic [7:0] data;   // key code
		logic [1:0] ktype;  // source kind, adjust keys only
		logic       strobe;
	} key_t;

	// per-frame screen snapshot
	typedef struct packed {
		crop_t             crop;
		logic [`CNT_W-1:0] hsize; // active pixels per line
		logic [`CNT_W-1:0] vsize; // active lines per frame
		logic [1:0]        res;
		logic [6:0]        flg;   // mode change counter
	} screen_info_t;

endpackage

`default_nettype wire

/* video_crop_tb.sv */
// Testbench for the video border-crop unit.
// Generates a small raster, sends crop keys and resolution changes, and checks
// the display enable window and the per-frame snapshot against a reference model.

`default_nettype none

`include "video_crop_consts.svh"

module video_crop_tb
	import video_crop_pkg::*;
;

	localparam int H_TOTAL        = 200; // clocks per line
	localparam int HS_W           = 16;
	localparam int HA_START       = 64;  // first active pixel
	localparam int HA_W           = 80;
	localparam int V_TOTAL        = 44;  // lines per frame
	localparam int VS_W           = 3;
	localparam int VA_START       = 12;  // first active line
	localparam int VA_H           = 20;
	localparam int FRAME_LEN      = H_TOTAL * V_TOTAL;
	localparam int NUM_FRAMES     = 24;
	localparam int TIMEOUT_CYCLES = 2 * NUM_FRAMES * FRAME_LEN;
	localparam int H_LIM          = 32;  // offset range kept inside forced margins
	localparam int V_LIM          = 6;
	localparam int SCR_CHECK_X    = 100; // well after the snapshot update

	logic         clk_28;
	logic         reset;
	raster_t      raster;
	logic [1:0]   res;
	key_t         key;
	logic         de;
	screen_info_t scr;

	integer       seed;
	logic         running;
	int           x;
	int           y;
	int           frame;
	int           cycles;
	int           errors;
	int           line_de;     // de clocks in the current line
	int           frame_lines; // lines with de in the current frame
	int           de_frames;
	int           scr_checks;
	int           exp_w;
	int           exp_h;
	int           f;
	crop_t        model_crop;
	logic         alt_model;
	screen_info_t exp_scr;

	video_crop UUT (
		.clk_28 (clk_28),
		.reset  (reset),
		.raster (raster),
		.res    (res),
		.key    (key),
		.de     (de),
		.scr    (scr)
	);

	always #4 clk_28 = ~clk_28;

	//////////////////////////////
	// reference model
	//////////////////////////////
	function automatic crop_t next_crop(input crop_t c, input logic alt_held,
			input logic [7:0] code);
		crop_t n;
		n = c;
		case (code)
			`KEY_CLEAR: n = '0;
			`KEY_UP: begin
				if (alt_held)
					n.vbl_b = c.vbl_b + `V_STEP;
				else
					n.vbl_t = c.vbl_t + `V_STEP;
			end
			`KEY_DOWN: begin
				if (alt_held)
					n.vbl_b = c.vbl_b - `V_STEP;
				else
					n.vbl_t = c.vbl_t - `V_STEP;
			end
			`KEY_LEFT: begin
				if (alt_held)
					n.hbl_r = c.hbl_r + `H_STEP;
				else
					n.hbl_l = c.hbl_l + `H_STEP;
			end
			`KEY_RIGHT: begin
				if (alt_held)
					n.hbl_r = c.hbl_r - `H_STEP;
				else
					n.hbl_l = c.hbl_l - `H_STEP;
			end
			default: n = c;
		endcase
		return n;
	endfunction

	// snapshot at frame start, flg counts mode changes
	function automatic screen_info_t expected_screen(input screen_info_t prev, input crop_t c,
			input logic [`CNT_W-1:0] hs, input logic [`CNT_W-1:0] vs, input logic [1:0] r);
		screen_info_t s;
		s       = prev;
		s.crop  = c;
		s.hsize = hs;
		s.vsize = vs;
		s.res   = r;
		if (r != prev.res || hs != prev.hsize || vs != prev.vsize)
			s.flg = prev.flg + 7'd1;
		return s;
	endfunction

	function automatic bit in_limits(input crop_t c);
		return ($signed(c.hbl_l) >= -H_LIM) && ($signed(c.hbl_l) <= H_LIM)
			&& ($signed(c.hbl_r) >= -H_LIM) && ($signed(c.hbl_r) <= H_LIM)
			&& ($signed(c.vbl_t) >= -V_LIM) && ($signed(c.vbl_t) <= V_LIM)
			&& ($signed(c.vbl_b) >= -V_LIM) && ($signed(c.vbl_b) <= V_LIM);
	endfunction

	// turn a cursor key around when it would leave the allowed range
	function automatic logic [7:0] bounded_code(input logic [7:0] code, input crop_t c,
			input logic alt_held);
		logic [7:0] opposite;
		case (code)
			`KEY_UP:    opposite = `KEY_DOWN;
			`KEY_DOWN:  opposite = `KEY_UP;
			`KEY_LEFT:  opposite = `KEY_RIGHT;
			`KEY_RIGHT: opposite = `KEY_LEFT;
			default:    opposite = code;
		endcase
		if (in_limits(next_crop(c, alt_held, code)))
			return code;
		return opposite;
	endfunction

	function automatic raster_t raster_at(input int px, input int ln);
		raster_t r;
		r.hs_n   = (px >= HS_W);
		r.vs_n   = (ln >= VS_W);
		r.hblank = !(px >= HA_START && px < HA_START + HA_W);
		r.vblank = !(ln >= VA_START && ln < VA_START + VA_H);
		return r;
	endfunction

	task automatic check_value(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		if (expected !== actual) begin
			errors = errors + 1;
			$display("error %s expected %0h actual %0h", name, expected, actual);
			$display("Some tests failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	//////////////////////////////
	// stimulus tasks
	//////////////////////////////
	task automatic wait_frame_begin();
		do
			@(posedge clk_28);
		while (!(x == 2 && y == 0));
	endtask

	task automatic send_key(input logic [7:0] code, input logic [1:0] kind, input int hold);
		@(posedge clk_28);
		key.data   <= code;
		key.ktype  <= kind;
		key.strobe <= 1'b1;
		repeat (hold - 1) @(posedge clk_28); // strobe held high
		@(posedge clk_28);
		key.strobe <= 1'b0;
		@(posedge clk_28);
		if (kind == `KEY_TYPE_ADJ) begin
			case (code)
				`KEY_ALT_L_DN, `KEY_ALT_R_DN: alt_model = 1'b1;
				`KEY_ALT_L_UP, `KEY_ALT_R_UP: alt_model = 1'b0;
				default: model_crop = next_crop(model_crop, alt_model, code);
			endcase
		end
	endtask

	task automatic random_burst(input int count);
		int         i;
		int         pick;
		logic [7:0] code;
		for (i = 0; i < count; i++) begin
			pick = $unsigned($random(seed)) % 6;
			case (pick)
				0:       code = `KEY_UP;
				1:       code = `KEY_DOWN;
				2:       code = `KEY_LEFT;
				3:       code = `KEY_RIGHT;
				4:       code = ($random(seed) & 1) ? `KEY_ALT_L_DN : `KEY_ALT_R_DN;
				default: code = ($random(seed) & 1) ? `KEY_ALT_L_UP : `KEY_ALT_R_UP;
			endcase
			code = bounded_code(code, model_crop, alt_model);
			send_key(code, `KEY_TYPE_ADJ, 1 + $unsigned($random(seed)) % 3);
		end
	endtask

	task automatic filter_keys();
		send_key(`KEY_LEFT, 2'd0, 1); // wrong type, no effect
		send_key(`KEY_RIGHT, 2'd1, 2);
		send_key(`KEY_UP, 2'd2, 1);
		send_key(bounded_code(`KEY_LEFT, model_crop, alt_model), `KEY_TYPE_ADJ, 6);
		send_key(bounded_code(`KEY_DOWN, model_crop, alt_model), `KEY_TYPE_ADJ, 4);
	endtask

	task automatic change_res();
		logic [1:0] next_res;
		next_res = res ^ (2'd1 + 2'($unsigned($random(seed)) % 3)); // always differs
		@(posedge clk_28);
		res <= next_res;
	endtask

	//////////////////////////////
	// raster generator
	//////////////////////////////
	always @(posedge clk_28) begin
		if (running) begin
			raster <= raster_at(x, y);
			if (x == H_TOTAL - 1) begin
				x <= 0;
				if (y == V_TOTAL - 1) begin
					y     <= 0;
					frame <= frame + 1;
				end else begin
					y <= y + 1;
				end
			end else begin
				x <= x + 1;
			end
		end
	end

	// de window and snapshot checks
	always @(negedge clk_28) begin
		if (running) begin
			if (de)
				line_de = line_de + 1;
			if (x == H_TOTAL - 1) begin
				if (frame >= 2 && line_de != 0) begin
					exp_w = HA_W - $signed(model_crop.hbl_l) + $signed(model_crop.hbl_r);
					check_value("de width", exp_w, line_de);
					frame_lines = frame_lines + 1;
				end
				line_de = 0;
				if (y == V_TOTAL - 1) begin
					if (frame >= 2) begin
						exp_h = VA_H - $signed(model_crop.vbl_t) + $signed(model_crop.vbl_b);
						check_value("de height", exp_h, frame_lines);
						de_frames = de_frames + 1;
					end
					frame_lines = 0;
				end
			end
			if (y == VA_START && x == SCR_CHECK_X) begin
				exp_scr = expected_screen(exp_scr, model_crop, HA_W, (frame == 0) ? 0 : VA_H, res);
				check_value("snapshot crop", exp_scr.crop, scr.crop);
				check_value("snapshot hsize", exp_scr.hsize, scr.hsize);
				check_value("snapshot vsize", exp_scr.vsize, scr.vsize);
				check_value("snapshot res", exp_scr.res, scr.res);
				check_value("snapshot flg", exp_scr.flg, scr.flg);
				scr_checks = scr_checks + 1;
			end
		end
	end

	always @(negedge clk_28) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the frame sequence never completed", cycles);
			$display("Some tests failed");
			$fatal(1, "simulation timed out");
		end
	end

	initial begin
		seed        = 32'hdee0f4d9;
		clk_28      = 1'b0;
		reset       = 1'b1;
		raster      = 4'b1111; // idle, both syncs high and blanked
		res         = 2'd0;
		key         = '0;
		running     = 1'b0;
		x           = 0;
		y           = 0;
		frame       = 0;
		cycles      = 0;
		errors      = 0;
		line_de     = 0;
		frame_lines = 0;
		de_frames   = 0;
		scr_checks  = 0;
		model_crop  = '0;
		alt_model   = 1'b0;
		exp_scr     = '0;

		repeat (10) @(posedge clk_28);
		reset <= 1'b0;
		@(negedge clk_28);
		check_value("reset de", 0, de);
		check_value("reset scr", 0, scr);
		@(posedge clk_28);
		running <= 1'b1;

		for (f = 0; f < NUM_FRAMES; f++) begin
			wait_frame_begin();
			if (f >= 3 && f <= 10)
				random_burst(6);
			else if (f == 11)
				filter_keys();
			else if (f >= 12 && f <= 15)
				random_burst(8);
			else if (f == 16)
				send_key(`KEY_CLEAR, `KEY_TYPE_ADJ, 1);
			else if (f >= 17 && (f % 2) == 1)
				change_res(); // even frames keep res
		end
		wait_frame_begin(); // last frame fully checked

		check_value("de frames checked", NUM_FRAMES - 2, de_frames);
		check_value("snapshots checked", NUM_FRAMES, scr_checks);
		if (errors == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$fatal(1, "mismatches were counted during the run");
		end
	end

endmodule

`default_nettype wire
